//--- verilog/ex_ctrl_pkg.sv
package ex_ctrl_pkg;

    // {funct7[5], funct3} of the R-type encoding
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sll  = 4'b0001,
        alu_slt  = 4'b0010,
        alu_sltu = 4'b0011,
        alu_xor  = 4'b0100,
        alu_srl  = 4'b0101,
        alu_or   = 4'b0110,
        alu_and  = 4'b0111,
        alu_sub  = 4'b1000,
        alu_sra  = 4'b1101
    } alu_ops_t;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t; // same as branch funct3

    typedef enum logic {
        alumux1_rs1_out = 1'b0,
        alumux1_pc_out  = 1'b1
    } alumux1_sel_t;

    typedef enum logic [2:0] {
        alumux2_i_imm   = 3'd0,
        alumux2_u_imm   = 3'd1,
        alumux2_b_imm   = 3'd2,
        alumux2_s_imm   = 3'd3,
        alumux2_j_imm   = 3'd4,
        alumux2_rs2_out = 3'd5
    } alumux2_sel_t;

    typedef enum logic {
        cmpmux_rs2_out = 1'b0,
        cmpmux_i_imm   = 1'b1
    } cmpmux_sel_t;

    typedef enum logic {
        marmux_pc_out  = 1'b0,
        marmux_alu_out = 1'b1
    } marmux_sel_t;

    typedef enum logic [1:0] {
        id_ex_fd  = 2'd0, // no forwarding, regfile value
        ex_mem_fd = 2'd1,
        mem_wb_fd = 2'd2
    } data_forward_t;

    typedef enum logic [1:0] {
        pcmux_pc_plus4 = 2'd0,
        pcmux_alu_out  = 2'd1,
        pcmux_alu_mod2 = 2'd2  // jalr, bit 0 cleared
    } pcmux_sel_t;

    typedef struct packed {
        alu_ops_t       aluop;
        branch_funct3_t cmpop;
        alumux1_sel_t   alumux1_sel;
        alumux2_sel_t   alumux2_sel;
        cmpmux_sel_t    cmpmux_sel;
        marmux_sel_t    marmux_sel;
        logic           is_branch;
    } ex_ctrlwd_t;

endpackage

//--- verilog/rv32i_types_pkg.sv
package rv32i_types_pkg;

    typedef logic [31:0] rv32i_word;
    typedef logic [4:0]  rv32i_reg;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode_t;

    // decoded instruction as it enters execute
    typedef struct packed {
        logic                   valid;
        ex_ctrl_pkg::ex_ctrlwd_t ctrl;
        rv32i_opcode_t          opcode;
        rv32i_word              pc;
        rv32i_reg               rs1;
        rv32i_reg               rs2;
        rv32i_reg               rd;
        logic                   load_regfile;
        rv32i_word              rs1_out;  // regfile read data
        rv32i_word              rs2_out;
        rv32i_word              i_imm;
        rv32i_word              u_imm;
        rv32i_word              b_imm;
        rv32i_word              s_imm;
        rv32i_word              j_imm;
    } id_ex_t;

    typedef struct packed {
        logic          valid;
        rv32i_reg      rd;
        logic          load_regfile;
        rv32i_word     alu_out;       // write-back value
        rv32i_word     mar;
        rv32i_word     mem_data_out;  // lane aligned store data
        logic          cmp_out;
        rv32i_opcode_t opcode;
        rv32i_word     pc;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        rv32i_reg  rd;
        logic      load_regfile;
        rv32i_word rd_data;
    } mem_wb_t;

endpackage

//--- verilog/alu.sv
`timescale 1ns/100ps

module alu (
    input  ex_ctrl_pkg::alu_ops_t   aluop,
    input  rv32i_types_pkg::rv32i_word a,
    input  rv32i_types_pkg::rv32i_word b,
    output rv32i_types_pkg::rv32i_word f
);

    logic [4:0] shamt;

    assign shamt = b[4:0]; // rv32i shifts ignore upper bits

    always_comb begin
        case (aluop)
            ex_ctrl_pkg::alu_add:  f = a + b;
            ex_ctrl_pkg::alu_sub:  f = a - b;
            ex_ctrl_pkg::alu_sll:  f = a << shamt;
            ex_ctrl_pkg::alu_srl:  f = a >> shamt;
            ex_ctrl_pkg::alu_sra:  f = rv32i_types_pkg::rv32i_word'($signed(a) >>> shamt);
            ex_ctrl_pkg::alu_xor:  f = a ^ b;
            ex_ctrl_pkg::alu_or:   f = a | b;
            ex_ctrl_pkg::alu_and:  f = a & b;
            ex_ctrl_pkg::alu_slt: begin
                f = {31'd0, $signed(a) < $signed(b)};
            end
            ex_ctrl_pkg::alu_sltu: begin
                f = {31'd0, a < b};
            end
            default: f = a + b;
        endcase
    end

endmodule

//--- verilog/cmp.sv
`timescale 1ns/100ps

module cmp (
    input  ex_ctrl_pkg::branch_funct3_t cmpop,
    input  rv32i_types_pkg::rv32i_word  a,
    input  rv32i_types_pkg::rv32i_word  b,
    output logic                        br_en
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (a == b);
    assign lt_s = ($signed(a) < $signed(b));
    assign lt_u = (a < b);

    always_comb begin
        case (cmpop)
            ex_ctrl_pkg::beq:  br_en = eq;
            ex_ctrl_pkg::bne:  br_en = ~eq;
            ex_ctrl_pkg::blt:  br_en = lt_s;
            ex_ctrl_pkg::bge:  br_en = ~lt_s;
            ex_ctrl_pkg::bltu: br_en = lt_u;
            ex_ctrl_pkg::bgeu: br_en = ~lt_u;
            default:           br_en = 1'b0; // unused funct3
        endcase
    end

endmodule

//--- verilog/forward_unit.sv
`timescale 1ns/100ps

module forward_unit (
    input  rv32i_types_pkg::rv32i_reg  ex_to_mem_rd,
    input  rv32i_types_pkg::rv32i_reg  mem_to_wb_rd,
    input  rv32i_types_pkg::rv32i_reg  id_to_ex_rs1,
    input  rv32i_types_pkg::rv32i_reg  id_to_ex_rs2,
    input  logic                       ex_to_mem_load_regfile, // already gated by valid
    input  logic                       mem_to_wb_load_regfile,
    output ex_ctrl_pkg::data_forward_t forward_a,
    output ex_ctrl_pkg::data_forward_t forward_b
);

    // newest writer wins, x0 never forwarded
    function automatic ex_ctrl_pkg::data_forward_t pick_src(
        input rv32i_types_pkg::rv32i_reg rs
    );
        if (ex_to_mem_load_regfile && (ex_to_mem_rd != '0) && (ex_to_mem_rd == rs)) begin
            return ex_ctrl_pkg::ex_mem_fd;
        end else if (mem_to_wb_load_regfile && (mem_to_wb_rd != '0) &&
                     (mem_to_wb_rd == rs)) begin
            return ex_ctrl_pkg::mem_wb_fd;
        end
        return ex_ctrl_pkg::id_ex_fd;
    endfunction

    assign forward_a = pick_src(id_to_ex_rs1);
    assign forward_b = pick_src(id_to_ex_rs2);

endmodule

//--- verilog/execute.sv
`timescale 1ns/100ps

module execute (
    input  rv32i_types_pkg::id_ex_t    ex_in,
    input  rv32i_types_pkg::rv32i_reg  ex_to_mem_rd,
    input  rv32i_types_pkg::rv32i_reg  mem_to_wb_rd,
    input  logic                       ex_to_mem_load_regfile,
    input  logic                       mem_to_wb_load_regfile,
    input  rv32i_types_pkg::rv32i_word ex_mem_rd_data,
    input  rv32i_types_pkg::rv32i_word mem_wb_rd_data,
    output rv32i_types_pkg::ex_mem_t   ex_out,
    output ex_ctrl_pkg::pcmux_sel_t    pcmux_sel,
    output rv32i_types_pkg::rv32i_word branch_target,
    output logic                       branch_take
);

    ex_ctrl_pkg::data_forward_t forward_a;
    ex_ctrl_pkg::data_forward_t forward_b;
    rv32i_types_pkg::rv32i_word forward_rs1;
    rv32i_types_pkg::rv32i_word forward_rs2;
    rv32i_types_pkg::rv32i_word alumux1_out;
    rv32i_types_pkg::rv32i_word alumux2_out;
    rv32i_types_pkg::rv32i_word cmpmux_out;
    rv32i_types_pkg::rv32i_word marmux_out;
    rv32i_types_pkg::rv32i_word alu_out;
    rv32i_types_pkg::rv32i_word pc_plus4;
    rv32i_types_pkg::rv32i_word wb_value;
    logic                       br_en;
    logic                       is_jal;
    logic                       is_jalr;

    assign is_jal   = (ex_in.opcode == rv32i_types_pkg::op_jal);
    assign is_jalr  = (ex_in.opcode == rv32i_types_pkg::op_jalr);
    assign pc_plus4 = ex_in.pc + 32'd4;

    forward_unit forward_unit_i (
        .ex_to_mem_rd           (ex_to_mem_rd),
        .mem_to_wb_rd           (mem_to_wb_rd),
        .id_to_ex_rs1           (ex_in.rs1),
        .id_to_ex_rs2           (ex_in.rs2),
        .ex_to_mem_load_regfile (ex_to_mem_load_regfile),
        .mem_to_wb_load_regfile (mem_to_wb_load_regfile),
        .forward_a              (forward_a),
        .forward_b              (forward_b)
    );

    alu alu_i (
        .aluop (ex_in.ctrl.aluop),
        .a     (alumux1_out),
        .b     (alumux2_out),
        .f     (alu_out)
    );

    cmp cmp_i (
        .cmpop (ex_in.ctrl.cmpop),
        .a     (forward_rs1),
        .b     (cmpmux_out),
        .br_en (br_en)
    );

    always_comb begin
        case (forward_a)
            ex_ctrl_pkg::ex_mem_fd: forward_rs1 = ex_mem_rd_data;
            ex_ctrl_pkg::mem_wb_fd: forward_rs1 = mem_wb_rd_data;
            default:                forward_rs1 = ex_in.rs1_out;
        endcase
        case (forward_b)
            ex_ctrl_pkg::ex_mem_fd: forward_rs2 = ex_mem_rd_data;
            ex_ctrl_pkg::mem_wb_fd: forward_rs2 = mem_wb_rd_data;
            default:                forward_rs2 = ex_in.rs2_out;
        endcase
    end

    // operand muxes, all after forwarding
    always_comb begin
        alumux1_out = (ex_in.ctrl.alumux1_sel == ex_ctrl_pkg::alumux1_pc_out) ?
                      ex_in.pc : forward_rs1;
        case (ex_in.ctrl.alumux2_sel)
            ex_ctrl_pkg::alumux2_u_imm: alumux2_out = ex_in.u_imm;
            ex_ctrl_pkg::alumux2_b_imm: alumux2_out = ex_in.b_imm;
            ex_ctrl_pkg::alumux2_s_imm: alumux2_out = ex_in.s_imm;
            ex_ctrl_pkg::alumux2_j_imm: alumux2_out = ex_in.j_imm;
            ex_ctrl_pkg::alumux2_rs2_out: alumux2_out = forward_rs2;
            default: alumux2_out = ex_in.i_imm;
        endcase
        cmpmux_out = (ex_in.ctrl.cmpmux_sel == ex_ctrl_pkg::cmpmux_i_imm) ?
                     ex_in.i_imm : forward_rs2;
        marmux_out = (ex_in.ctrl.marmux_sel == ex_ctrl_pkg::marmux_alu_out) ?
                     alu_out : ex_in.pc;
    end

    // redirect only for a valid instruction in ID/EX
    always_comb begin
        branch_take   = 1'b0;
        pcmux_sel     = ex_ctrl_pkg::pcmux_pc_plus4;
        branch_target = pc_plus4;
        if (ex_in.valid) begin
            if (is_jalr) begin
                branch_take   = 1'b1;
                pcmux_sel     = ex_ctrl_pkg::pcmux_alu_mod2;
                branch_target = {alu_out[31:1], 1'b0};
            end else if (is_jal || (br_en && ex_in.ctrl.is_branch)) begin
                branch_take   = 1'b1;
                pcmux_sel     = ex_ctrl_pkg::pcmux_alu_out;
                branch_target = alu_out;
            end
        end
    end

    always_comb begin
        case (ex_in.opcode)
            rv32i_types_pkg::op_lui:  wb_value = ex_in.u_imm;
            rv32i_types_pkg::op_jal,
            rv32i_types_pkg::op_jalr: wb_value = pc_plus4; // link address
            default:                  wb_value = alu_out;
        endcase
    end

    always_comb begin
        ex_out.valid        = ex_in.valid;
        ex_out.rd           = ex_in.rd;
        ex_out.load_regfile = ex_in.load_regfile;
        ex_out.alu_out      = wb_value;
        ex_out.mar          = marmux_out;
        ex_out.mem_data_out = forward_rs2 << {marmux_out[1:0], 3'b000}; // byte lane shift
        ex_out.cmp_out      = br_en; // slt result bit for write-back
        ex_out.opcode       = ex_in.opcode;
        ex_out.pc           = ex_in.pc;
    end

endmodule

//--- verilog/ex_stage_top.sv
`timescale 1ns/100ps

module ex_stage_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  rv32i_types_pkg::id_ex_t    id_ex_in,
    input  logic                       mem_ready,
    output rv32i_types_pkg::ex_mem_t   ex_mem_out,
    output rv32i_types_pkg::mem_wb_t   mem_wb_out,
    output ex_ctrl_pkg::pcmux_sel_t    pcmux_sel,
    output rv32i_types_pkg::rv32i_word branch_target,
    output logic                       branch_take
);

    rv32i_types_pkg::id_ex_t    id_ex_q;
    rv32i_types_pkg::id_ex_t    id_ex_cur;
    rv32i_types_pkg::ex_mem_t   ex_mem_q;
    rv32i_types_pkg::ex_mem_t   ex_mem_d;
    rv32i_types_pkg::rv32i_reg  mem_wb_rd;
    rv32i_types_pkg::rv32i_word mem_wb_data;
    logic                       mem_wb_load;
    logic                       id_ex_vld;
    logic                       ex_mem_vld;
    logic                       mem_wb_vld;

    // valid bits, everything moves only with mem_ready
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex_vld  <= 1'b0;
            ex_mem_vld <= 1'b0;
            mem_wb_vld <= 1'b0;
        end else if (mem_ready) begin
            id_ex_vld  <= id_ex_in.valid & ~branch_take; // squash slot behind redirect
            ex_mem_vld <= ex_mem_d.valid;
            mem_wb_vld <= ex_mem_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_ready) begin
            id_ex_q     <= id_ex_in;
            ex_mem_q    <= ex_mem_d;
            mem_wb_rd   <= ex_mem_q.rd;
            mem_wb_load <= ex_mem_q.load_regfile;
            mem_wb_data <= ex_mem_q.alu_out; // no load data in this stage model
        end
    end

    always_comb begin
        id_ex_cur       = id_ex_q;
        id_ex_cur.valid = id_ex_vld;
    end

    execute execute_i (
        .ex_in                  (id_ex_cur),
        .ex_to_mem_rd           (ex_mem_q.rd),
        .mem_to_wb_rd           (mem_wb_rd),
        .ex_to_mem_load_regfile (ex_mem_vld & ex_mem_q.load_regfile),
        .mem_to_wb_load_regfile (mem_wb_vld & mem_wb_load),
        .ex_mem_rd_data         (ex_mem_q.alu_out),
        .mem_wb_rd_data         (mem_wb_data),
        .ex_out                 (ex_mem_d),
        .pcmux_sel              (pcmux_sel),
        .branch_target          (branch_target),
        .branch_take            (branch_take)
    );

    always_comb begin
        ex_mem_out       = ex_mem_q;
        ex_mem_out.valid = ex_mem_vld;
    end

    assign mem_wb_out = '{valid:        mem_wb_vld,
                          rd:           mem_wb_rd,
                          load_regfile: mem_wb_load,
                          rd_data:      mem_wb_data};

endmodule

//--- tests/ex_stage_props.sv
`timescale 1ns/100ps

module ex_stage_props (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       mem_ready,
    input rv32i_types_pkg::ex_mem_t   ex_mem_out,
    input rv32i_types_pkg::mem_wb_t   mem_wb_out,
    input ex_ctrl_pkg::pcmux_sel_t    pcmux_sel,
    input logic                       branch_take
);

    // pipeline frozen while memory stalls
    hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        !mem_ready |=> $stable(ex_mem_out) && $stable(mem_wb_out))
        else $error("pipeline registers moved during a stall");

    // slot behind a taken redirect is squashed
    flush_after_take: assert property (@(posedge clk) disable iff (!rst_n)
        branch_take && mem_ready |=> !branch_take && pcmux_sel == ex_ctrl_pkg::pcmux_pc_plus4)
        else $error("slot behind a taken redirect was not flushed");

    take_held: assert property (@(posedge clk) disable iff (!rst_n)
        branch_take && !mem_ready |=> branch_take)
        else $error("branch_take dropped under back-pressure");

    wb_follows: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ready && ex_mem_out.valid |=> mem_wb_out.valid)
        else $error("valid EX/MEM entry did not reach MEM/WB");

endmodule

bind ex_stage_top ex_stage_props props_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .mem_ready   (mem_ready),
    .ex_mem_out  (ex_mem_out),
    .mem_wb_out  (mem_wb_out),
    .pcmux_sel   (pcmux_sel),
    .branch_take (branch_take)
);

//--- tests/ex_stage_tb.sv
`timescale 1ns/100ps

module ex_stage_tb;

    typedef struct packed {
        rv32i_types_pkg::id_ex_t    stim;
        rv32i_types_pkg::ex_mem_t   exp;
        logic                       take;
        ex_ctrl_pkg::pcmux_sel_t    psel;
        rv32i_types_pkg::rv32i_word target;
        logic                       flushed;
    } golden_t;

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic                       mem_ready;
    rv32i_types_pkg::id_ex_t    id_ex_in;
    rv32i_types_pkg::ex_mem_t   ex_mem_out;
    rv32i_types_pkg::mem_wb_t   mem_wb_out;
    ex_ctrl_pkg::pcmux_sel_t    pcmux_sel;
    rv32i_types_pkg::rv32i_word branch_target;
    logic                       branch_take;

    golden_t                    golden[$];
    int                         pending[$]; // accepted, not yet on ex_mem_out
    int                         wb_pending[$]; // on ex_mem_out, MEM/WB next
    int                         line_fail[64];
    rv32i_types_pkg::rv32i_word regs[32];   // register file model
    rv32i_types_pkg::ex_mem_t   last_ex_mem;
    logic [31:0]                lfsr = 32'h9ab4465c;
    int                         errors = 0;
    int                         checked = 0;
    int                         expected_count = 0;
    int                         cycles = 0;
    int                         next_line = 0;
    int                         idex_line = -1;
    int                         limit;

    always #20 clk = ~clk;

    ex_stage_top dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .id_ex_in      (id_ex_in),
        .mem_ready     (mem_ready),
        .ex_mem_out    (ex_mem_out),
        .mem_wb_out    (mem_wb_out),
        .pcmux_sel     (pcmux_sel),
        .branch_target (branch_target),
        .branch_take   (branch_take)
    );

    function automatic logic lfsr_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) lfsr = lfsr ^ 32'h80200003; // galois taps
        return b;
    endfunction

    // rv32i branch conditions on architectural values
    function automatic logic branch_cond(input ex_ctrl_pkg::branch_funct3_t op,
                                         input rv32i_types_pkg::rv32i_word a,
                                         input rv32i_types_pkg::rv32i_word b);
        case (op)
            ex_ctrl_pkg::beq:  return a == b;
            ex_ctrl_pkg::bne:  return a != b;
            ex_ctrl_pkg::blt:  return $signed(a) < $signed(b);
            ex_ctrl_pkg::bge:  return $signed(a) >= $signed(b);
            ex_ctrl_pkg::bltu: return a < b;
            ex_ctrl_pkg::bgeu: return a >= b;
            default:           return 1'b0;
        endcase
    endfunction

    task automatic read_golden();
        int fd;
        int n;
        string line;
        logic [31:0] f[21];
        golden_t g;
        rv32i_types_pkg::rv32i_word arch[32]; // program order register values
        rv32i_types_pkg::rv32i_word cmp_b;
        for (int i = 0; i < 32; i++) arch[i] = '0;
        fd = $fopen("tests/ex_stage_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/ex_stage_golden.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.substr(0, 0) == "#") continue;
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                            f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20]);
                if (n != 21) continue;
                g = '0;
                g.stim.valid            = 1'b1;
                g.stim.opcode           = rv32i_types_pkg::rv32i_opcode_t'(f[0][6:0]);
                g.stim.ctrl.aluop       = ex_ctrl_pkg::alu_ops_t'(f[1][3:0]);
                g.stim.ctrl.cmpop       = ex_ctrl_pkg::branch_funct3_t'(f[2][2:0]);
                g.stim.ctrl.alumux1_sel = ex_ctrl_pkg::alumux1_sel_t'(f[3][0]);
                g.stim.ctrl.alumux2_sel = ex_ctrl_pkg::alumux2_sel_t'(f[4][2:0]);
                g.stim.ctrl.cmpmux_sel  = ex_ctrl_pkg::cmpmux_sel_t'(f[5][0]);
                g.stim.ctrl.marmux_sel  = ex_ctrl_pkg::marmux_sel_t'(f[6][0]);
                g.stim.ctrl.is_branch   = f[7][0];
                g.stim.rs1              = f[8][4:0];
                g.stim.rs2              = f[9][4:0];
                g.stim.rd               = f[10][4:0];
                g.stim.load_regfile     = f[11][0];
                g.stim.pc               = f[12];
                g.stim.i_imm            = f[13]; // one immediate feeds every format
                g.stim.u_imm            = f[13];
                g.stim.b_imm            = f[13];
                g.stim.s_imm            = f[13];
                g.stim.j_imm            = f[13];
                g.exp.valid             = 1'b1;
                g.exp.rd                = g.stim.rd;
                g.exp.load_regfile      = g.stim.load_regfile;
                g.exp.alu_out           = f[14];
                g.exp.mar               = f[15];
                g.exp.mem_data_out      = f[16];
                g.exp.opcode            = g.stim.opcode;
                g.exp.pc                = g.stim.pc;
                cmp_b = (g.stim.ctrl.cmpmux_sel == ex_ctrl_pkg::cmpmux_i_imm) ?
                        f[13] : arch[g.stim.rs2];
                g.exp.cmp_out           = branch_cond(g.stim.ctrl.cmpop, arch[g.stim.rs1], cmp_b);
                g.take                  = f[17][0];
                g.psel                  = ex_ctrl_pkg::pcmux_sel_t'(f[18][1:0]);
                g.target                = f[19];
                g.flushed               = f[20][0];
                if (!g.flushed) begin
                    expected_count++;
                    if (g.stim.load_regfile && g.stim.rd != 0) arch[g.stim.rd] = f[14];
                end
                golden.push_back(g);
            end
            $fclose(fd);
        end
    endtask

    task automatic check_ex_mem(input rv32i_types_pkg::ex_mem_t got,
                                input rv32i_types_pkg::ex_mem_t exp, input int idx);
        if (got !== exp) begin
            errors++;
            if (idx >= 0) line_fail[idx]++;
            $display("Error at %0t: line %0d ex_mem_out %h, expected %h", $time, idx, got, exp);
        end
    endtask

    task automatic check_mem_wb(input rv32i_types_pkg::mem_wb_t got,
                                input rv32i_types_pkg::mem_wb_t exp, input int idx);
        if (got !== exp) begin
            errors++;
            if (idx >= 0) line_fail[idx]++;
            $display("Error at %0t: line %0d mem_wb_out %h, expected %h", $time, idx, got, exp);
        end
    endtask

    task automatic check_redirect(input ex_ctrl_pkg::pcmux_sel_t psel,
                                  input rv32i_types_pkg::rv32i_word target, input logic take,
                                  input golden_t g, input int idx);
        if (take !== g.take || psel !== g.psel || (g.take && target !== g.target)) begin
            errors++;
            if (idx >= 0) line_fail[idx]++;
            $display("Error at %0t: line %0d redirect take %b sel %0d target %h, expected %b %0d %h",
                     $time, idx, take, psel, target, g.take, g.psel, g.target);
        end
    endtask

    task automatic step_cycle();
        logic adv;
        logic force_next;
        int cur;
        golden_t g;
        rv32i_types_pkg::mem_wb_t wb_exp;
        adv = mem_ready; // what the last rising edge saw
        force_next = 1'b0;
        if (adv) begin
            if (wb_pending.size() != 0) begin
                cur = wb_pending.pop_front();
                wb_exp.valid        = 1'b1;
                wb_exp.rd           = golden[cur].exp.rd;
                wb_exp.load_regfile = golden[cur].exp.load_regfile;
                wb_exp.rd_data      = golden[cur].exp.alu_out; // no load data in this model
                check_mem_wb(mem_wb_out, wb_exp, cur);
                if (wb_exp.load_regfile && wb_exp.rd != 0) begin
                    regs[wb_exp.rd] = wb_exp.rd_data;
                end
                checked++;
                $display("line %0d pc %h: %s", cur, golden[cur].stim.pc,
                         (line_fail[cur] == 0) ? "ok" : "failed");
            end else if (mem_wb_out.valid) begin
                errors++;
                $display("MEM/WB held a valid entry that never passed through EX/MEM");
            end
            if (ex_mem_out.valid) begin
                if (pending.size() == 0) begin
                    errors++;
                    $display("instruction at pc %h appeared twice or was never sent", ex_mem_out.pc);
                end else begin
                    cur = pending.pop_front();
                    check_ex_mem(ex_mem_out, golden[cur].exp, cur);
                    wb_pending.push_back(cur);
                end
            end
            idex_line = -1;
            if (id_ex_in.valid) begin
                cur = next_line;
                next_line++;
                force_next = golden[cur].take; // slot behind a redirect must be filled
                if (golden[cur].flushed) begin
                    $display("line %0d pc %h: flushed", cur, golden[cur].stim.pc);
                end else begin
                    pending.push_back(cur);
                    idex_line = cur;
                end
            end
        end else begin
            check_ex_mem(ex_mem_out, last_ex_mem, -1);
        end
        g = '0; // empty slot, no redirect
        if (idex_line >= 0) g = golden[idex_line];
        check_redirect(pcmux_sel, branch_target, branch_take, g, idex_line);
        last_ex_mem = ex_mem_out;
        if (adv || !id_ex_in.valid) begin
            if (next_line < golden.size() && (force_next || !(lfsr_bit() & lfsr_bit()))) begin
                g = golden[next_line];
                g.stim.rs1_out = regs[g.stim.rs1]; // write-through regfile read
                g.stim.rs2_out = regs[g.stim.rs2];
                id_ex_in = g.stim;
            end else begin
                id_ex_in = '0; // bubble
            end
        end
        mem_ready = !(lfsr_bit() & lfsr_bit());
    endtask

    initial begin
        rst_n = 1'b0;
        mem_ready = 1'b0;
        id_ex_in = '0;
        for (int i = 0; i < 32; i++) regs[i] = '0;
        read_golden();
        limit = 3 * golden.size() + 50;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        last_ex_mem = ex_mem_out;
        while (cycles < limit &&
               !(next_line >= golden.size() && pending.size() == 0 &&
                 wb_pending.size() == 0 && !id_ex_in.valid)) begin
            @(negedge clk);
            cycles++;
            step_cycle();
        end
        if (cycles >= limit) begin
            errors++;
            $display("run stopped after %0d cycles without finishing the golden lines", cycles);
        end
        if (checked != expected_count || golden.size() == 0) begin
            errors++;
            $display("only %0d of %0d instructions came out of the pipeline", checked, expected_count);
        end
        $display("%0d instructions checked, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- tests/ex_stage_golden.txt
# op alu cmp m1 m2 cmux mmux br rs1 rs2 rd ld pc imm, then expected:
# alu_out mar store_data take pcsel target flushed (all hex)
37 0 0 0 1 0 0 0 00 00 01 1 00000100 80000000 80000000 00000100 00000000 0 0 00000000 0
13 0 0 0 0 0 0 0 00 00 02 1 00000104 000007ff 000007ff 00000104 00000000 0 0 00000000 0
33 0 0 0 5 0 0 0 01 02 03 1 00000108 00000000 800007ff 00000108 000007ff 0 0 00000000 0
33 8 0 0 5 0 0 0 02 01 04 1 0000010c 00000000 800007ff 0000010c 80000000 0 0 00000000 0
33 d 0 0 5 0 0 0 01 02 05 1 00000110 00000000 ffffffff 00000110 000007ff 0 0 00000000 0
13 d 0 0 0 0 0 0 01 00 06 1 00000114 00000004 f8000000 00000114 00000000 0 0 00000000 0
13 5 0 0 0 0 0 0 01 00 07 1 00000118 00000004 08000000 00000118 00000000 0 0 00000000 0
33 2 0 0 5 0 0 0 01 02 08 1 0000011c 00000000 00000001 0000011c 000007ff 0 0 00000000 0
13 3 0 0 0 0 0 0 01 00 09 1 00000120 000007ff 00000000 00000120 00000000 0 0 00000000 0
33 4 0 0 5 0 0 0 03 04 0a 1 00000124 00000000 00000000 00000124 800007ff 0 0 00000000 0
13 6 0 0 0 0 0 0 02 00 0b 1 00000128 fffff800 ffffffff 00000128 00000000 0 0 00000000 0
33 7 0 0 5 0 0 0 01 05 0c 1 0000012c 00000000 80000000 0000012c ffffffff 0 0 00000000 0
33 1 0 0 5 0 0 0 02 02 0d 1 00000130 00000000 80000000 00000130 000007ff 0 0 00000000 0
13 0 0 0 0 0 0 0 02 00 00 1 00000134 00000005 00000804 00000134 00000000 0 0 00000000 0
33 0 0 0 5 0 0 0 00 00 0e 1 00000138 00000000 00000000 00000138 00000000 0 0 00000000 0
13 0 0 0 0 0 0 0 02 00 02 1 0000013c 00000001 00000800 0000013c 00000000 0 0 00000000 0
13 0 0 0 0 0 0 0 02 00 02 1 00000140 00000001 00000801 00000140 00000000 0 0 00000000 0
13 0 0 0 0 0 0 0 02 00 02 1 00000144 00000001 00000802 00000144 00000000 0 0 00000000 0
23 0 0 0 3 0 1 0 01 02 00 0 00000148 00000002 80000002 80000002 08020000 0 0 00000000 0
63 0 0 1 2 0 0 1 03 04 00 0 0000014c 00000010 0000015c 0000014c 800007ff 1 1 0000015c 0
13 0 0 0 0 0 0 0 00 00 0f 1 00000150 00000001 00000000 00000000 00000000 0 0 00000000 1
63 0 1 1 2 0 0 1 03 04 00 0 0000015c 00000020 0000017c 0000015c 800007ff 0 0 00000000 0
63 0 4 1 2 0 0 1 01 02 00 0 00000160 fffffff8 00000158 00000160 00000802 1 1 00000158 0
13 0 0 0 0 0 0 0 00 00 0f 1 00000164 00000001 00000000 00000000 00000000 0 0 00000000 1
63 0 5 1 2 0 0 1 01 02 00 0 00000168 00000008 00000170 00000168 00000802 0 0 00000000 0
63 0 6 1 2 0 0 1 01 02 00 0 0000016c 00000008 00000174 0000016c 00000802 0 0 00000000 0
63 0 7 1 2 0 0 1 01 02 00 0 00000170 00000040 000001b0 00000170 00000802 1 1 000001b0 0
13 0 0 0 0 0 0 0 00 00 0f 1 00000174 00000001 00000000 00000000 00000000 0 0 00000000 1
6f 0 0 1 4 0 0 0 00 00 10 1 000001b0 00000100 000001b4 000001b0 00000000 1 1 000002b0 0
13 0 0 0 0 0 0 0 00 00 0f 1 000001b4 00000001 00000000 00000000 00000000 0 0 00000000 1
67 0 0 0 0 0 0 0 10 00 11 1 000002b0 00000003 000002b4 000002b0 00000000 1 2 000001b6 0
13 0 0 0 0 0 0 0 00 00 11 1 000002b4 00000055 00000000 00000000 00000000 0 0 00000000 1
33 0 0 0 5 0 0 0 11 10 12 1 000001b8 00000000 00000468 000001b8 000001b4 0 0 00000000 0

//--- ex_stage_top.f
verilog/ex_ctrl_pkg.sv
verilog/rv32i_types_pkg.sv
verilog/alu.sv
verilog/cmp.sv
verilog/forward_unit.sv
verilog/execute.sv
verilog/ex_stage_top.sv
tests/ex_stage_props.sv
tests/ex_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run from the project root
verilator --binary --timing --assert --top-module ex_stage_tb -f ex_stage_top.f \
    -o ex_stage_sim > build.log 2>&1 \
    && ./obj_dir/ex_stage_sim > sim.log 2>&1 \
    || { echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "^Everything OK$" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
